// ==== hw/arbiter.sv ====
// Fixed eight-slot time-division arbiter for the shared RAM bus
// The slot advances on clk8_en_i, one pulse in every eight clocks
// Video owns four slots, spi1 two and the CPU two
// During CPU slots requests are masked and stalls held high
// cpu_grant_en_o pulses in the first cycle of CPU_1
module arbiter (
    input  logic                                 wb_clock_i,
    input  logic                                 rst_n_i,
    input  logic                                 clk8_en_i,

    // spi1 controller
    input  logic [common_pkg::WB_ADDR_WIDTH-1:0] spi1_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]    spi1_dout_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    spi1_din_o,
    input  logic                                 spi1_we_i,
    input  logic                                 spi1_cycle_i,
    input  logic                                 spi1_strobe_i,
    output logic                                 spi1_stall_o,
    output logic                                 spi1_ack_o,

    // Video controller
    input  logic [common_pkg::WB_ADDR_WIDTH-1:0] video_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]    video_dout_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    video_din_o,
    input  logic                                 video_we_i,
    input  logic                                 video_cycle_i,
    input  logic                                 video_strobe_i,
    output logic                                 video_stall_o,
    output logic                                 video_ack_o,

    // Shared bus
    output logic [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [common_pkg::DATA_WIDTH-1:0]    wb_dout_o,
    input  logic [common_pkg::DATA_WIDTH-1:0]    wb_din_i,
    output logic                                 wb_we_o,
    output logic                                 wb_cycle_o,
    output logic                                 wb_strobe_o,
    input  logic                                 wb_stall_i,
    input  logic                                 wb_ack_i,

    output logic                                 cpu_grant_en_o
);
    localparam int COUNT       = common_pkg::CONTROLLER_COUNT;
    localparam int GRANT_WIDTH = (COUNT > 1) ? $clog2(COUNT) : 1;

    logic [common_pkg::SLOT_WIDTH-1:0] slot;
    logic                              grant_valid;  // First cycle of a slot
    logic                              cpu_slot;
    logic [GRANT_WIDTH-1:0]            wbc_grant;
    logic [COUNT-1:0]                  wbc_stall;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot        <= common_pkg::SPI_2;  // First enable moves to VIDEO_1
            grant_valid <= 1'b0;
        end else begin
            if (clk8_en_i) begin
                slot <= slot + 1'b1;
            end
            grant_valid <= clk8_en_i;
        end
    end

    // Slot ownership
    always_comb begin
        cpu_slot  = 1'b0;
        wbc_grant = GRANT_WIDTH'(0);
        case (slot)
            common_pkg::CPU_1, common_pkg::CPU_2: cpu_slot  = 1'b1;
            common_pkg::SPI_1, common_pkg::SPI_2: wbc_grant = GRANT_WIDTH'(1);
            default:                              wbc_grant = GRANT_WIDTH'(0);  // Video
        endcase
    end

    wb_demux #(
        .COUNT(COUNT)
    ) wb_demux_inst (
        .wb_clock_i       (wb_clock_i),
        .rst_n_i          (rst_n_i),
        .wbc_cycle_i      ({spi1_cycle_i, video_cycle_i}),
        .wbc_strobe_i     ({spi1_strobe_i, video_strobe_i} & {COUNT{!cpu_slot}}),
        .wbc_we_i         ({spi1_we_i, video_we_i}),
        .wbc_addr_i       ({spi1_addr_i, video_addr_i}),
        .wbc_dout_i       ({spi1_dout_i, video_dout_i}),
        .wbc_din_o        ({spi1_din_o, video_din_o}),
        .wbc_stall_o      (wbc_stall),
        .wbc_ack_o        ({spi1_ack_o, video_ack_o}),
        .wbc_grant_i      (wbc_grant),
        .wbc_grant_valid_i(grant_valid && !cpu_slot),  // No window in CPU slots
        .wb_addr_o        (wb_addr_o),
        .wb_dout_o        (wb_dout_o),
        .wb_din_i         (wb_din_i),
        .wb_we_o          (wb_we_o),
        .wb_cycle_o       (wb_cycle_o),
        .wb_strobe_o      (wb_strobe_o),
        .wb_stall_i       (wb_stall_i),
        .wb_ack_i         (wb_ack_i)
    );

    // Masked requests must also look stalled to their controller
    assign video_stall_o = wbc_stall[0] || cpu_slot;
    assign spi1_stall_o  = wbc_stall[1] || cpu_slot;

    assign cpu_grant_en_o = grant_valid && (slot == common_pkg::CPU_1);

endmodule

// ==== hw/common_pkg.sv ====
// Shared widths and slot encodings for the PET shared-memory bus
// Addresses are word addresses, one byte per word
// Slot encodings follow the order of the eight-slot frame
package common_pkg;

    localparam int WB_ADDR_WIDTH = 16;
    localparam int DATA_WIDTH    = 8;
    localparam int SLOT_WIDTH    = 3;

    // Frame order, four video, two CPU, two spi1
    localparam logic [SLOT_WIDTH-1:0] VIDEO_1 = 3'd0;
    localparam logic [SLOT_WIDTH-1:0] VIDEO_2 = 3'd1;
    localparam logic [SLOT_WIDTH-1:0] VIDEO_3 = 3'd2;
    localparam logic [SLOT_WIDTH-1:0] VIDEO_4 = 3'd3;
    localparam logic [SLOT_WIDTH-1:0] CPU_1   = 3'd4;
    localparam logic [SLOT_WIDTH-1:0] CPU_2   = 3'd5;
    localparam logic [SLOT_WIDTH-1:0] SPI_1   = 3'd6;
    localparam logic [SLOT_WIDTH-1:0] SPI_2   = 3'd7;

    localparam int RAM_ADDR_BITS_DEFAULT = 10;

    // Index 0 is video, index 1 is spi1
    localparam int CONTROLLER_COUNT = 2;

endpackage

// ==== hw/pet_bus_top.sv ====
// Shared-memory bus of the PET clone, arbiter plus one RAM
// Video and spi1 reach the RAM through a fixed slot schedule
// clk8_en_i must pulse once every eight clocks
module pet_bus_top #(
    parameter int RAM_ADDR_BITS = common_pkg::RAM_ADDR_BITS_DEFAULT
) (
    input  logic                                 wb_clock_i,
    input  logic                                 rst_n_i,
    input  logic                                 clk8_en_i,

    input  logic [common_pkg::WB_ADDR_WIDTH-1:0] spi1_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]    spi1_dout_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    spi1_din_o,
    input  logic                                 spi1_we_i,
    input  logic                                 spi1_cycle_i,
    input  logic                                 spi1_strobe_i,
    output logic                                 spi1_stall_o,
    output logic                                 spi1_ack_o,

    input  logic [common_pkg::WB_ADDR_WIDTH-1:0] video_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]    video_dout_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    video_din_o,
    input  logic                                 video_we_i,
    input  logic                                 video_cycle_i,
    input  logic                                 video_strobe_i,
    output logic                                 video_stall_o,
    output logic                                 video_ack_o,

    output logic                                 cpu_grant_en_o
);
    // Shared bus between arbiter and RAM
    logic [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr;
    logic [common_pkg::DATA_WIDTH-1:0]    wb_dout;
    logic [common_pkg::DATA_WIDTH-1:0]    wb_din;
    logic                                 wb_we;
    logic                                 wb_cycle;
    logic                                 wb_strobe;
    logic                                 wb_stall;
    logic                                 wb_ack;

    arbiter arbiter_inst (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .clk8_en_i     (clk8_en_i),
        .spi1_addr_i   (spi1_addr_i),
        .spi1_dout_i   (spi1_dout_i),
        .spi1_din_o    (spi1_din_o),
        .spi1_we_i     (spi1_we_i),
        .spi1_cycle_i  (spi1_cycle_i),
        .spi1_strobe_i (spi1_strobe_i),
        .spi1_stall_o  (spi1_stall_o),
        .spi1_ack_o    (spi1_ack_o),
        .video_addr_i  (video_addr_i),
        .video_dout_i  (video_dout_i),
        .video_din_o   (video_din_o),
        .video_we_i    (video_we_i),
        .video_cycle_i (video_cycle_i),
        .video_strobe_i(video_strobe_i),
        .video_stall_o (video_stall_o),
        .video_ack_o   (video_ack_o),
        .wb_addr_o     (wb_addr),
        .wb_dout_o     (wb_dout),
        .wb_din_i      (wb_din),
        .wb_we_o       (wb_we),
        .wb_cycle_o    (wb_cycle),
        .wb_strobe_o   (wb_strobe),
        .wb_stall_i    (wb_stall),
        .wb_ack_i      (wb_ack),
        .cpu_grant_en_o(cpu_grant_en_o)
    );

    sram_target #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) sram_target_inst (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .wb_addr_i  (wb_addr),
        .wb_dout_i  (wb_dout),
        .wb_din_o   (wb_din),
        .wb_we_i    (wb_we),
        .wb_cycle_i (wb_cycle),
        .wb_strobe_i(wb_strobe),
        .wb_stall_o (wb_stall),
        .wb_ack_o   (wb_ack)
    );

endmodule

// ==== hw/sram_target.sv ====
// Byte-wide Wishbone pipelined RAM of 2**RAM_ADDR_BITS entries
// Only the low RAM_ADDR_BITS address bits are used, so addresses wrap
// RAM_ADDR_BITS must not exceed the bus address width
// Reads ack one cycle after acceptance with the data
// Writes ack one cycle after acceptance and stall for that cycle
// RAM contents are undefined after power-up
module sram_target #(
    parameter int RAM_ADDR_BITS = common_pkg::RAM_ADDR_BITS_DEFAULT
) (
    input  logic                                 wb_clock_i,
    input  logic                                 rst_n_i,

    input  logic [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [common_pkg::DATA_WIDTH-1:0]    wb_dout_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    wb_din_o,
    input  logic                                 wb_we_i,
    input  logic                                 wb_cycle_i,
    input  logic                                 wb_strobe_i,
    output logic                                 wb_stall_o,
    output logic                                 wb_ack_o
);
    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    logic [common_pkg::DATA_WIDTH-1:0] mem [DEPTH];
    logic [RAM_ADDR_BITS-1:0]          index;
    logic                              accept;

    assign index  = wb_addr_i[RAM_ADDR_BITS-1:0];
    assign accept = wb_cycle_i && wb_strobe_i && !wb_stall_o;

    // Handshake state
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o   <= 1'b0;
            wb_stall_o <= 1'b0;
        end else begin
            wb_ack_o   <= accept;
            wb_stall_o <= accept && wb_we_i;  // Write recovery cycle
        end
    end

    // Storage and read data
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            if (wb_we_i) begin
                mem[index] <= wb_dout_i;
            end else begin
                wb_din_o <= mem[index];
            end
        end
    end

endmodule

// ==== hw/wb_demux.sv ====
// Steers one of COUNT Wishbone pipelined controllers onto a shared bus
// A window opens on wbc_grant_valid_i for controller wbc_grant_i
// and closes on the first bus ack or the next grant-valid
// At most one transfer is passed per window
// wbc_grant_i must be below COUNT when wbc_grant_valid_i is high
// Controllers outside the window see stall high and ack low
module wb_demux #(
    parameter int COUNT = 2
) (
    input  logic                                          wb_clock_i,
    input  logic                                          rst_n_i,

    // Controller side, one lane per controller
    input  logic [COUNT-1:0]                              wbc_cycle_i,
    input  logic [COUNT-1:0]                              wbc_strobe_i,
    input  logic [COUNT-1:0]                              wbc_we_i,
    input  logic [COUNT*common_pkg::WB_ADDR_WIDTH-1:0]    wbc_addr_i,
    input  logic [COUNT*common_pkg::DATA_WIDTH-1:0]       wbc_dout_i,
    output logic [COUNT*common_pkg::DATA_WIDTH-1:0]       wbc_din_o,
    output logic [COUNT-1:0]                              wbc_stall_o,
    output logic [COUNT-1:0]                              wbc_ack_o,

    input  logic [((COUNT > 1) ? $clog2(COUNT) : 1)-1:0]  wbc_grant_i,
    input  logic                                          wbc_grant_valid_i,

    // Shared bus
    output logic [common_pkg::WB_ADDR_WIDTH-1:0]          wb_addr_o,
    output logic [common_pkg::DATA_WIDTH-1:0]             wb_dout_o,
    input  logic [common_pkg::DATA_WIDTH-1:0]             wb_din_i,
    output logic                                          wb_we_o,
    output logic                                          wb_cycle_o,
    output logic                                          wb_strobe_o,
    input  logic                                          wb_stall_i,
    input  logic                                          wb_ack_i
);
    localparam int GRANT_WIDTH = (COUNT > 1) ? $clog2(COUNT) : 1;
    localparam int AW = common_pkg::WB_ADDR_WIDTH;
    localparam int DW = common_pkg::DATA_WIDTH;

    logic [GRANT_WIDTH-1:0] sel;      // Controller owning the window
    logic                   open;     // Window open
    logic                   pending;  // Transfer accepted, ack not yet seen
    logic                   accept;

    assign accept = wb_strobe_o && !wb_stall_i;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel     <= '0;
            open    <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (wbc_grant_valid_i) begin
                sel  <= wbc_grant_i;
                open <= 1'b1;
            end else if (wb_ack_i) begin
                open <= 1'b0;  // One transfer per window
            end

            if (accept) begin
                pending <= 1'b1;
            end else if (wb_ack_i) begin
                pending <= 1'b0;
            end
        end
    end

    // Request fields of the selected lane go straight to the bus
    // The old window ends with the grant-valid cycle
    assign wb_addr_o   = wbc_addr_i[int'(sel)*AW +: AW];
    assign wb_dout_o   = wbc_dout_i[int'(sel)*DW +: DW];
    assign wb_we_o     = wbc_we_i[sel];
    assign wb_cycle_o  = open && wbc_cycle_i[sel];
    assign wb_strobe_o = open && !pending && !wbc_grant_valid_i
                         && wbc_cycle_i[sel] && wbc_strobe_i[sel];

    always_comb begin
        wbc_stall_o = '1;
        wbc_ack_o   = '0;
        wbc_din_o   = '0;
        if (open) begin
            wbc_stall_o[sel]                = pending || wbc_grant_valid_i || wb_stall_i;
            wbc_ack_o[sel]                  = wb_ack_i;
            wbc_din_o[int'(sel)*DW +: DW]   = wb_din_i;
        end
    end

endmodule

// ==== pet_bus_arbiter.f ====
hw/common_pkg.sv
hw/wb_demux.sv
hw/arbiter.sv
hw/sram_target.sv
hw/pet_bus_top.sv
tests/pet_bus_props.sv
tests/pet_bus_tb.sv

// ==== tests/pet_bus_props.sv ====
// Handshake and grant rules on the shared bus, bound into the arbiter
// Assumes one transfer in flight on the shared bus at a time
module pet_bus_props (
    input logic wb_clock_i,
    input logic rst_n_i,
    input logic wb_cycle_o,
    input logic wb_strobe_o,
    input logic wb_stall_i,
    input logic wb_ack_i,
    input logic spi1_ack_o,
    input logic video_ack_o,
    input logic cpu_grant_en_o
);
    logic in_flight;  // Accepted on the bus, no ack yet
    int   failures = 0;  // Count of failed assertions

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_flight <= 1'b0;
        end else if (wb_strobe_o && !wb_stall_i) begin
            in_flight <= 1'b1;
        end else if (wb_ack_i) begin
            in_flight <= 1'b0;
        end
    end

    strobe_needs_cycle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_strobe_o |-> wb_cycle_o)
    else begin
        $error("strobe without cycle");
        failures++;
    end
    single_cpu_pulse: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_grant_en_o |=> !cpu_grant_en_o)
    else begin
        $error("CPU grant longer than one cycle");
        failures++;
    end
    one_ack: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        !(spi1_ack_o && video_ack_o))
    else begin
        $error("two controller acks at once");
        failures++;
    end
    ack_after_accept: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (spi1_ack_o || video_ack_o) |-> in_flight)
    else begin
        $error("ack with nothing accepted");
        failures++;
    end

endmodule

bind arbiter pet_bus_props props_inst (.*);

// ==== tests/pet_bus_tb.sv ====
// Testbench for the PET shared bus: spi1 and video against a RAM model
// Stimulus moves 10 units after each rising edge, outputs sampled at falling edges
// RAM is 1024 bytes, so addresses wrap modulo 1024
module pet_bus_tb;
    localparam int AW = common_pkg::WB_ADDR_WIDTH;
    localparam int DW = common_pkg::DATA_WIDTH;
    localparam int RAM_BITS = 10;
    localparam int DEPTH = 2 ** RAM_BITS;
    localparam int LIMIT = 200 * 16 * 8 + 16;  // Cycle budget for the run

    logic wb_clock_i, rst_n_i, clk8_en_i, cpu_grant_en_o;
    logic [AW-1:0] spi1_addr_i, video_addr_i;
    logic [DW-1:0] spi1_dout_i, video_dout_i, spi1_din_o, video_din_o;
    logic spi1_we_i, spi1_cycle_i, spi1_strobe_i, spi1_stall_o, spi1_ack_o;
    logic video_we_i, video_cycle_i, video_strobe_i, video_stall_o, video_ack_o;

    logic [DW-1:0] model [DEPTH];
    logic [DW-1:0] spi1_exp, video_exp;
    logic spi1_out = 0, video_out = 0, spi1_rd = 0;
    int seed = 32'ha4af3144;
    int errors = 0, passes = 0, cycles = 0, en_count = 0, div = 0;
    int spi1_acks = 0, video_acks = 0, frames = 0;
    logic [2:0] tb_slot = 3'd7;  // Slot after reset is SPI_2
    logic en_seen = 0, load_on = 0, frame_started = 0;
    logic [AW-1:0] addrs [$];

    pet_bus_top #(.RAM_ADDR_BITS(RAM_BITS)) pet_bus_top_inst (.*);

    function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] addr);
        return model[addr % DEPTH];
    endfunction

    task automatic check_data(input string name, input logic [DW-1:0] got, exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end else passes++;
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end else passes++;
    endtask

    task automatic spi1_transfer(input logic we, input logic [AW-1:0] addr,
                                 input logic [DW-1:0] data);
        int n;
        {spi1_we_i, spi1_addr_i, spi1_dout_i} = {we, addr, data};
        spi1_cycle_i = 1;
        spi1_strobe_i = 1;
        n = 0;
        @(negedge wb_clock_i);
        while (spi1_stall_o && n < 400) begin  // Back-pressure, keep strobe up
            @(negedge wb_clock_i);
            n++;
        end
        if (spi1_stall_o) begin
            $display("spi1 request at %0t was never accepted", $time);
            errors++;
        end else begin
            spi1_exp = we ? data : expected_read(addr);
            spi1_rd = !we;
            if (we) model[addr % DEPTH] = data;
            spi1_out = 1;
        end
        @(posedge wb_clock_i);
        #10 spi1_strobe_i = 0;
        n = 0;
        while (spi1_out && n < 64) begin
            @(posedge wb_clock_i);
            n++;
        end
        if (spi1_out) begin
            $display("spi1 got no ack within 64 cycles at %0t", $time);
            errors++;
            spi1_out = 0;
        end
        #10 spi1_cycle_i = 0;
    endtask

    task automatic video_transfer(input logic [AW-1:0] addr);
        int n;
        {video_we_i, video_addr_i, video_dout_i} = {1'b0, addr, 8'h00};
        video_cycle_i = 1;
        video_strobe_i = 1;
        n = 0;
        @(negedge wb_clock_i);
        while (video_stall_o && n < 400) begin
            @(negedge wb_clock_i);
            n++;
        end
        if (video_stall_o) begin
            $display("video request at %0t was never accepted", $time);
            errors++;
        end else begin
            video_exp = expected_read(addr);
            video_out = 1;
        end
        @(posedge wb_clock_i);
        #10 video_strobe_i = 0;
        n = 0;
        while (video_out && n < 64) begin
            @(posedge wb_clock_i);
            n++;
        end
        if (video_out) begin
            $display("video got no ack within 64 cycles at %0t", $time);
            errors++;
            video_out = 0;
        end
        #10 video_cycle_i = 0;
    endtask

    initial begin
        wb_clock_i = 0;
        forever #50 wb_clock_i = ~wb_clock_i;
    end

    // Own enable counter, slot tracking and frame accounting
    always @(posedge wb_clock_i) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Run stopped after %0d cycles, cycle limit reached", cycles);
            $display("TB FAILED");
            $finish;
        end else begin
            en_seen = clk8_en_i;
            if (clk8_en_i) begin
                en_count++;
                tb_slot = tb_slot + 1;
                if (tb_slot == 0) begin  // New frame
                    if (load_on && frame_started) begin
                        check_flag("video acks in 1..4", video_acks >= 1 && video_acks <= 4, 1);
                        check_flag("spi1 acks in 1..2", spi1_acks >= 1 && spi1_acks <= 2, 1);
                        frames++;
                    end
                    frame_started = load_on;
                    spi1_acks = 0;
                    video_acks = 0;
                end
            end
            if (rst_n_i) begin  // Enable divider runs out of reset only
                div = (div + 1) % 8;
                #10 clk8_en_i = (div == 0);
            end
        end
    end

    // Compare process
    always @(negedge wb_clock_i) begin
        if (rst_n_i) begin
            check_flag("cpu_grant_en_o", cpu_grant_en_o, en_seen && (en_count % 8 == 5));
            if (spi1_ack_o) begin
                check_flag("spi1_ack_o", 1'b1, spi1_out);
                check_flag("spi1_ack_o in CPU slot", tb_slot == 4 || tb_slot == 5, 0);
                if (spi1_rd) check_data("spi1_din_o", spi1_din_o, spi1_exp);
                spi1_out = 0;
                spi1_acks++;
            end
            if (video_ack_o) begin
                check_flag("video_ack_o", 1'b1, video_out);
                check_flag("video_ack_o in CPU slot", tb_slot == 4 || tb_slot == 5, 0);
                check_data("video_din_o", video_din_o, video_exp);
                video_out = 0;
                video_acks++;
            end
        end
    end

    initial begin
        logic [AW-1:0] a;
        {rst_n_i, clk8_en_i, spi1_addr_i, spi1_dout_i, spi1_we_i} = '0;
        {spi1_cycle_i, spi1_strobe_i, video_addr_i, video_dout_i} = '0;
        {video_we_i, video_cycle_i, video_strobe_i} = '0;
        repeat (16) @(posedge wb_clock_i);
        #10 rst_n_i = 1;
        @(negedge wb_clock_i);
        check_flag("spi1_stall_o", spi1_stall_o, 1);
        check_flag("video_stall_o", video_stall_o, 1);
        check_flag("spi1_ack_o", spi1_ack_o, 0);
        check_flag("video_ack_o", video_ack_o, 0);
        @(posedge wb_clock_i);
        #10 $display("Test 1 reset state done, errors %0d", errors);
        repeat (50) begin
            a = $random(seed);
            addrs.push_back(a);
            spi1_transfer(1, a, $random(seed));
        end
        foreach (addrs[i]) spi1_transfer(0, addrs[i], 0);
        $display("Test 2 spi1 write and read back done, errors %0d", errors);
        for (int i = 0; i < 32; i++) spi1_transfer(1, i, $random(seed));
        repeat (32) video_transfer(($random(seed) & 31) | (($random(seed) & 63) << 10));
        $display("Test 3 video reads with wraparound done, errors %0d", errors);
        $display("Test 4 CPU grant pulse checked on every cycle so far, errors %0d", errors);
        load_on = 1;
        fork
            while (frames < 16) video_transfer(($random(seed) & 31) | ($random(seed) << 10));
            while (frames < 16) begin
                a = $random(seed) & 16'hfc1f;  // Low bits inside the filled area
                spi1_transfer(1, a, $random(seed));
                spi1_transfer(0, a, 0);
            end
        join
        load_on = 0;
        $display("Test 5 continuous load over 16 frames done, errors %0d", errors);
        errors += pet_bus_top_inst.arbiter_inst.props_inst.failures;
        $display("Checks passed %0d, failed %0d", passes, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
